// ==== common/zx_cfg.svh ====
`ifndef ZX_CFG_SVH
`define ZX_CFG_SVH

// ============================================================
// Address widths
// ============================================================

// Flat external memory, 32 MB of byte addresses
`define ZX_ADDR_W 25
// Z80 address bus
`define ZX_CPU_AW 16
// Offset inside a 16K bank or ROM page
`define ZX_BANK_AW 14

// ROM pages sit above the RAM banks in flat memory
`define ZX_ROM_BASE 25'h200000

// ============================================================
// Paging register bit positions
// ============================================================

// Port 7FFD
`define ZX_P7_LOCK 5
`define ZX_P7_ROM 4
`define ZX_P7_SCR 3

// Port 1FFD, +3 only
`define ZX_P1_SPECIAL 0
`define ZX_P1_ROMHI 2

`endif

// ==== common/zx_pkg.sv ====
package zx_pkg;

	// ============================================================
	// Machine model
	// ============================================================

	// Sampled from the model input while reset is high
	typedef enum logic [1:0] {
		MODEL_48K   = 2'd0,
		MODEL_128K  = 2'd1,
		MODEL_PLUS3 = 2'd2
	} machine_model_e;

	// ============================================================
	// I/O write classes
	// ============================================================

	// PORT_7FFD  A15=0, A14=1, A1=0
	// PORT_1FFD  A15..A13=0, A12=1, A1=0
	// PORT_LOW   A15=0, A14=0, A1=0 and not 1FFD
	typedef enum logic [1:0] {
		PORT_NONE = 2'd0,
		PORT_7FFD = 2'd1,
		PORT_1FFD = 2'd2,
		PORT_LOW  = 2'd3
	} page_port_e;

	// ============================================================
	// Register fields
	// ============================================================

	// One of eight 16K RAM banks
	typedef logic [2:0] ram_bank_t;

	// One of four 16K ROM pages
	typedef logic [1:0] rom_page_t;

endpackage

// ==== src/port_decode.sv ====
`timescale 1ns/1ps

`include "zx_cfg.svh"

module port_decode (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`ZX_CPU_AW-1:0] addr,
	input  logic                  n_iorq,
	input  logic                  n_wr,
	input  logic                  n_m1,
	output zx_pkg::page_port_e    port_class,
	output logic                  ula_wr
);

	import zx_pkg::*;

	logic       io_wr;
	logic       io_wr_q;
	logic       wr_start;
	logic       hit_7ffd;
	logic       hit_1ffd;
	logic       hit_low;
	page_port_e port_hit;

	// I/O write cycle, M1 high excludes interrupt acknowledge
	assign io_wr = ~n_iorq & ~n_wr & n_m1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	// Only the first cycle of a write counts, a held strobe is one write
	assign wr_start = io_wr & ~io_wr_q;

	// ============================================================
	// Partial address decode, as on the real machines
	// ============================================================

	assign hit_7ffd = ~addr[15] & addr[14] & ~addr[1];
	assign hit_1ffd = ~addr[15] & ~addr[14] & ~addr[13] & addr[12] & ~addr[1];
	assign hit_low  = ~addr[15] & ~addr[14] & ~addr[1] & ~hit_1ffd;

	always_comb begin
		if (hit_7ffd) begin
			port_hit = PORT_7FFD;
		end else if (hit_1ffd) begin
			port_hit = PORT_1FFD;
		end else if (hit_low) begin
			port_hit = PORT_LOW;
		end else begin
			port_hit = PORT_NONE;
		end
	end

	// Pulses last exactly one cycle
	assign port_class = wr_start ? port_hit : PORT_NONE;

	// ULA answers on any even port
	assign ula_wr = wr_start & ~addr[0];

endmodule

// ==== paging/port_regs.sv ====
`timescale 1ns/1ps

`include "zx_cfg.svh"

module port_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_pkg::machine_model_e model,
	input  zx_pkg::page_port_e     port_class,
	input  logic                   ula_wr,
	input  logic [7:0]             cpu_dout,
	output logic                   plus3,
	output logic                   zx48,
	output zx_pkg::ram_bank_t      ram_bank,
	output zx_pkg::rom_page_t      rom_page,
	output logic                   special,
	output logic [1:0]             special_cfg,
	output logic                   page_scr,
	output logic [2:0]             border_color,
	output logic                   ear_out,
	output logic                   mic_out
);

	import zx_pkg::*;

	machine_model_e model_q;
	// Bank, screen, ROM and lock bits of 7FFD
	logic [5:0]     reg_7ffd;
	// Special enable and the two config bits of 1FFD
	logic [2:0]     reg_1ffd;
	logic           locked;
	logic           wr_7ffd;
	logic           wr_1ffd;

	assign plus3  = (model_q == MODEL_PLUS3);
	assign zx48   = (model_q == MODEL_48K);
	assign locked = reg_7ffd[`ZX_P7_LOCK];

	// ============================================================
	// Write decode per model
	// ============================================================

	always_comb begin
		wr_7ffd = 1'b0;
		wr_1ffd = 1'b0;
		case (model_q)
			// 128K decodes only A15 and A1, so every class reaches 7FFD
			MODEL_128K: wr_7ffd = (port_class != PORT_NONE);
			MODEL_PLUS3: begin
				wr_7ffd = (port_class == PORT_7FFD);
				wr_1ffd = (port_class == PORT_1FFD);
			end
			default: begin
				wr_7ffd = 1'b0;
				wr_1ffd = 1'b0;
			end
		endcase
		// Lock holds until the next reset
		if (locked) begin
			wr_7ffd = 1'b0;
			wr_1ffd = 1'b0;
		end
	end

	// ============================================================
	// Paging registers
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q  <= model;
			reg_7ffd <= '0;
			reg_1ffd <= '0;
		end else begin
			if (wr_7ffd) begin
				reg_7ffd <= cpu_dout[5:0];
			end
			if (wr_1ffd) begin
				reg_1ffd <= cpu_dout[2:0];
			end
		end
	end

	assign ram_bank    = reg_7ffd[2:0];
	assign page_scr    = reg_7ffd[`ZX_P7_SCR];
	assign special     = reg_1ffd[`ZX_P1_SPECIAL];
	assign special_cfg = reg_1ffd[2:1];

	// +3 has four ROMs, the rest two; 48K stays on the BASIC ROM
	assign rom_page = plus3 ? {reg_1ffd[`ZX_P1_ROMHI], reg_7ffd[`ZX_P7_ROM]}
	                        : {1'b0, zx48 | reg_7ffd[`ZX_P7_ROM]};

	// ============================================================
	// ULA output port
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (ula_wr) begin
			border_color <= cpu_dout[2:0];
			ear_out      <= cpu_dout[4];
			mic_out      <= cpu_dout[3];
		end
	end

endmodule

// ==== paging/mem_map.sv ====
`timescale 1ns/1ps

`include "zx_cfg.svh"

module mem_map (
	input  logic [`ZX_CPU_AW-1:0]  addr,
	input  logic                   n_mreq,
	input  logic                   n_rd,
	input  logic                   n_wr,
	input  logic                   zx48,
	input  zx_pkg::ram_bank_t      ram_bank,
	input  zx_pkg::rom_page_t      rom_page,
	input  logic                   special,
	input  logic [1:0]             special_cfg,
	output logic [`ZX_ADDR_W-1:0]  mem_addr,
	output logic                   mem_rd,
	output logic                   mem_we,
	output logic                   rom_sel
);

	import zx_pkg::*;

	localparam int ROM_PAD = `ZX_ADDR_W - 2 - `ZX_BANK_AW;
	localparam int RAM_PAD = `ZX_ADDR_W - 3 - `ZX_BANK_AW;

	logic [1:0]             quad;
	logic [`ZX_BANK_AW-1:0] offset;
	ram_bank_t              bank;
	logic                   rom_hit;

	assign quad   = addr[15:14];
	assign offset = addr[`ZX_BANK_AW-1:0];

	// ============================================================
	// Bank selection per quadrant
	// ============================================================

	always_comb begin
		if (special) begin
			// +3 all-RAM configurations
			case (special_cfg)
				2'd0: bank = {1'b0, quad};
				2'd1: bank = {1'b1, quad};
				2'd2: bank = (quad == 2'd3) ? 3'd3 : {1'b1, quad};
				default: begin
					case (quad)
						2'd0: bank = 3'd4;
						2'd1: bank = 3'd7;
						2'd2: bank = 3'd6;
						default: bank = 3'd3;
					endcase
				end
			endcase
		end else begin
			case (quad)
				2'd1: bank = 3'd5;
				2'd2: bank = 3'd2;
				// 48K top quadrant is fixed to bank 0
				2'd3: bank = zx48 ? 3'd0 : ram_bank;
				default: bank = 3'd0;
			endcase
		end
	end

	// ============================================================
	// Flat address and strobes
	// ============================================================

	// Quadrant 0 is ROM unless special mode maps RAM there
	assign rom_hit = ~special & (quad == 2'd0);

	assign mem_addr = rom_hit ? (`ZX_ROM_BASE + {{ROM_PAD{1'b0}}, rom_page, offset})
	                          : {{RAM_PAD{1'b0}}, bank, offset};

	assign mem_rd  = ~n_mreq & ~n_rd;
	// ROM is write protected
	assign mem_we  = ~n_mreq & ~n_wr & ~rom_hit;
	assign rom_sel = rom_hit;

endmodule

// ==== src/zx_paging_top.sv ====
`timescale 1ns/1ps

`include "zx_cfg.svh"

module zx_paging_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_pkg::machine_model_e model,
	input  logic [`ZX_CPU_AW-1:0]  addr,
	input  logic [7:0]             cpu_dout,
	input  logic                   n_mreq,
	input  logic                   n_iorq,
	input  logic                   n_rd,
	input  logic                   n_wr,
	input  logic                   n_m1,
	output logic [`ZX_ADDR_W-1:0]  mem_addr,
	output logic                   mem_rd,
	output logic                   mem_we,
	output logic                   rom_sel,
	output logic                   page_scr,
	output logic [2:0]             border_color,
	output logic                   ear_out,
	output logic                   mic_out
);

	import zx_pkg::*;

	page_port_e port_class;
	logic       ula_wr;
	// Model flag kept visible for the bound checker
	logic       plus3;
	logic       zx48;
	logic       special;
	logic [1:0] special_cfg;
	rom_page_t  rom_page;
	ram_bank_t  ram_bank;

	// ============================================================
	// Decode, register update, memory cycle
	// ============================================================

	port_decode u_port_decode (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.addr       (addr),
		.n_iorq     (n_iorq),
		.n_wr       (n_wr),
		.n_m1       (n_m1),
		.port_class (port_class),
		.ula_wr     (ula_wr)
	);

	port_regs u_port_regs (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.model        (model),
		.port_class   (port_class),
		.ula_wr       (ula_wr),
		.cpu_dout     (cpu_dout),
		.plus3        (plus3),
		.zx48         (zx48),
		.ram_bank     (ram_bank),
		.rom_page     (rom_page),
		.special      (special),
		.special_cfg  (special_cfg),
		.page_scr     (page_scr),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	mem_map u_mem_map (
		.addr        (addr),
		.n_mreq      (n_mreq),
		.n_rd        (n_rd),
		.n_wr        (n_wr),
		.zx48        (zx48),
		.ram_bank    (ram_bank),
		.rom_page    (rom_page),
		.special     (special),
		.special_cfg (special_cfg),
		.mem_addr    (mem_addr),
		.mem_rd      (mem_rd),
		.mem_we      (mem_we),
		.rom_sel     (rom_sel)
	);

endmodule

// ==== dv/zx_paging_chk.sv ====
`timescale 1ns/1ps

`include "zx_cfg.svh"

module zx_paging_chk (
	input logic                  clk_sys,
	input logic                  reset,
	input logic [`ZX_CPU_AW-1:0] addr,
	input logic [7:0]            cpu_dout,
	input logic                  mem_we,
	input logic                  mem_rd,
	input logic                  special,
	input logic                  plus3,
	input logic                  zx48,
	input zx_pkg::page_port_e    port_class,
	input zx_pkg::ram_bank_t     ram_bank
);

	import zx_pkg::*;

	int   fail_count;
	logic paging_wr;
	logic lock_seen;

	initial fail_count = 0;

	// A write that reaches 7FFD in the latched model
	assign paging_wr = plus3 ? (port_class == PORT_7FFD)
	                         : (!zx48 && port_class != PORT_NONE);

	// Sticky until reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lock_seen <= 1'b0;
		end else if (paging_wr && cpu_dout[`ZX_P7_LOCK]) begin
			lock_seen <= 1'b1;
		end
	end

	// ============================================================
	// Properties
	// ============================================================

	rom_we_blocked: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem_we && addr[15:14] == 2'b00 && !special))
		else begin
			$error("Write strobe in quadrant 0 outside special mode");
			fail_count++;
		end

	rd_we_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem_we && mem_rd))
		else begin
			$error("mem_we and mem_rd high together");
			fail_count++;
		end

	bank_locked: assert property (@(posedge clk_sys) disable iff (reset)
		lock_seen |=> $stable(ram_bank))
		else begin
			$error("ram_bank changed after lock");
			fail_count++;
		end

endmodule

bind zx_paging_top zx_paging_chk u_chk (.*);

// ==== dv/zx_paging_tb.sv ====
`timescale 1ns/1ps

`include "zx_cfg.svh"

module zx_paging_tb;

	import zx_pkg::*;

	typedef enum logic [1:0] {OP_RESET, OP_IOWR, OP_MRD, OP_MWR} op_e;

	// One stimulus row; e_ula holds border, EAR, MIC
	typedef struct packed {
		op_e                   op;
		machine_model_e        mdl;
		logic [15:0]           a;
		logic [7:0]            d;
		logic                  rnd;
		logic [`ZX_ADDR_W-1:0] e_addr;
		logic                  e_we;
		logic                  e_scr;
		logic                  ula_chk;
		logic [4:0]            e_ula;
	} row_t;

	logic                  clk_sys;
	logic                  reset;
	machine_model_e        model;
	logic [`ZX_CPU_AW-1:0] addr;
	logic [7:0]            cpu_dout;
	logic                  n_mreq;
	logic                  n_iorq;
	logic                  n_rd;
	logic                  n_wr;
	logic                  n_m1;
	logic [`ZX_ADDR_W-1:0] mem_addr;
	logic                  mem_rd;
	logic                  mem_we;
	logic                  rom_sel;
	logic                  page_scr;
	logic [2:0]            border_color;
	logic                  ear_out;
	logic                  mic_out;

	row_t        rows[$];
	logic [31:0] lfsr_state;
	logic        ula_fixed;
	logic        wd_armed;
	int          wd_ns;

	zx_paging_top uut (.*);

	always #2 clk_sys = ~clk_sys;

	// ============================================================
	// Reference rules and helpers
	// ============================================================

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			b[i] = lfsr_state[0];
		end
	endtask

	function automatic logic [`ZX_ADDR_W-1:0] ram_addr(input ram_bank_t b,
			input logic [15:0] a);
		return {8'd0, b, a[`ZX_BANK_AW-1:0]};
	endfunction

	function automatic logic [`ZX_ADDR_W-1:0] rom_addr(input rom_page_t p,
			input logic [15:0] a);
		return `ZX_ROM_BASE + {9'd0, p, a[`ZX_BANK_AW-1:0]};
	endfunction

	// ULA port: border from bits 2..0, EAR bit 4, MIC bit 3
	function automatic logic [4:0] ula_expect(input logic [7:0] d);
		return {d[2:0], d[4], d[3]};
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got=0x%0h expected=0x%0h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "check of %s failed", name);
		end
	endtask

	task automatic add_row(input op_e op, input machine_model_e mdl, input logic [15:0] a,
			input logic [7:0] d, input logic [`ZX_ADDR_W-1:0] e_addr, input logic e_we,
			input logic e_scr);
		row_t r;
		if (op == OP_RESET)
			ula_fixed = 1'b1;
		r.op      = op;
		r.mdl     = mdl;
		r.a       = a;
		r.d       = d;
		r.rnd     = 1'b0;
		r.e_addr  = e_addr;
		r.e_we    = e_we;
		r.e_scr   = e_scr;
		r.ula_chk = ula_fixed;
		r.e_ula   = 5'd0;
		rows.push_back(r);
	endtask

	// ULA write with LFSR data, ULA state unknown to later rows until reset
	task automatic add_ula(input logic e_scr);
		row_t r;
		add_row(OP_IOWR, MODEL_PLUS3, 16'h00FE, 8'h00, '0, 1'b0, e_scr);
		r = rows.pop_back();
		r.rnd     = 1'b1;
		r.ula_chk = 1'b1;
		rows.push_back(r);
		ula_fixed = 1'b0;
	endtask

	task automatic run_row(input row_t r);
		logic [7:0] d;
		logic [4:0] e_ula;
		d     = r.d;
		e_ula = r.e_ula;
		if (r.rnd) begin
			draw_byte(d);
			e_ula = ula_expect(d);
		end
		case (r.op)
			OP_RESET: begin
				@(posedge clk_sys);
				model <= r.mdl;
				reset <= 1'b1;
				repeat (4) @(posedge clk_sys);
				reset <= 1'b0;
				@(negedge clk_sys);
				compare("mem_rd", 32'(mem_rd), 32'd0);
				compare("mem_we", 32'(mem_we), 32'd0);
			end
			OP_IOWR: begin
				@(posedge clk_sys);
				addr     <= r.a;
				cpu_dout <= d;
				n_iorq   <= 1'b0;
				n_wr     <= 1'b0;
				repeat (2) @(posedge clk_sys);
				n_iorq <= 1'b1;
				n_wr   <= 1'b1;
				@(posedge clk_sys);
				@(negedge clk_sys);
			end
			default: begin
				@(posedge clk_sys);
				addr   <= r.a;
				n_mreq <= 1'b0;
				if (r.op == OP_MRD)
					n_rd <= 1'b0;
				else
					n_wr <= 1'b0;
				@(negedge clk_sys);
				compare("mem_addr", 32'(mem_addr), 32'(r.e_addr));
				compare("mem_we", 32'(mem_we), 32'(r.e_we));
				compare("mem_rd", 32'(mem_rd), 32'(r.op == OP_MRD));
				compare("rom_sel", 32'(rom_sel), 32'(r.e_addr >= `ZX_ROM_BASE));
			end
		endcase
		compare("page_scr", 32'(page_scr), 32'(r.e_scr));
		if (r.ula_chk) begin
			compare("border_color", 32'(border_color), 32'(e_ula[4:2]));
			compare("ear_out", 32'(ear_out), 32'(e_ula[1]));
			compare("mic_out", 32'(mic_out), 32'(e_ula[0]));
		end
		if (r.op == OP_MRD || r.op == OP_MWR) begin
			@(posedge clk_sys);
			n_mreq <= 1'b1;
			n_rd   <= 1'b1;
			n_wr   <= 1'b1;
		end
	endtask

	// ============================================================
	// Stimulus table and run
	// ============================================================

	initial begin
		clk_sys    = 1'b0;
		reset      = 1'b1;
		model      = MODEL_128K;
		addr       = '0;
		cpu_dout   = '0;
		n_mreq     = 1'b1;
		n_iorq     = 1'b1;
		n_rd       = 1'b1;
		n_wr       = 1'b1;
		n_m1       = 1'b1;
		lfsr_state = 32'h4fc1a0fb;
		ula_fixed  = 1'b1;
		wd_armed   = 1'b0;

		// 128K fixed mapping, then 7FFD bank, ROM and screen bits
		add_row(OP_RESET, MODEL_128K, 16'h0000, 8'h00, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_128K, 16'h0000, 8'h00, rom_addr(2'd0, 16'h0000), 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_128K, 16'h4123, 8'h00, ram_addr(3'd5, 16'h4123), 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_128K, 16'h8001, 8'h00, ram_addr(3'd2, 16'h8001), 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_128K, 16'hC010, 8'h00, ram_addr(3'd0, 16'hC010), 1'b0, 1'b0);
		add_row(OP_MWR, MODEL_128K, 16'h0005, 8'h00, rom_addr(2'd0, 16'h0005), 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_128K, 16'h7FFD, 8'h1B, '0, 1'b0, 1'b1);
		add_row(OP_MRD, MODEL_128K, 16'hC004, 8'h00, ram_addr(3'd3, 16'hC004), 1'b0, 1'b1);
		add_row(OP_MRD, MODEL_128K, 16'h0100, 8'h00, rom_addr(2'd1, 16'h0100), 1'b0, 1'b1);
		add_row(OP_MWR, MODEL_128K, 16'hC000, 8'h00, ram_addr(3'd3, 16'hC000), 1'b1, 1'b1);
		// Low-address alias of 7FFD
		add_row(OP_IOWR, MODEL_128K, 16'h00FD, 8'h06, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_128K, 16'hC002, 8'h00, ram_addr(3'd6, 16'hC002), 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_128K, 16'h0000, 8'h00, rom_addr(2'd0, 16'h0000), 1'b0, 1'b0);
		// Lock with bank 1, the next write must not take
		add_row(OP_IOWR, MODEL_128K, 16'h7FFD, 8'h21, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_128K, 16'hC000, 8'h00, ram_addr(3'd1, 16'hC000), 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_128K, 16'h7FFD, 8'h1F, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_128K, 16'hC000, 8'h00, ram_addr(3'd1, 16'hC000), 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_128K, 16'h0000, 8'h00, rom_addr(2'd0, 16'h0000), 1'b0, 1'b0);
		add_row(OP_RESET, MODEL_128K, 16'h0000, 8'h00, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_128K, 16'hC000, 8'h00, ram_addr(3'd0, 16'hC000), 1'b0, 1'b0);
		// 48K
		add_row(OP_RESET, MODEL_48K, 16'h0000, 8'h00, '0, 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_48K, 16'h7FFD, 8'h1F, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_48K, 16'hC000, 8'h00, ram_addr(3'd0, 16'hC000), 1'b0, 1'b0);
		add_row(OP_MWR, MODEL_48K, 16'h1234, 8'h00, rom_addr(2'd1, 16'h1234), 1'b0, 1'b0);
		add_row(OP_MWR, MODEL_48K, 16'h5678, 8'h00, ram_addr(3'd5, 16'h5678), 1'b1, 1'b0);
		// +3 ROM pages, PORT_LOW is ignored here
		add_row(OP_RESET, MODEL_PLUS3, 16'h0000, 8'h00, '0, 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_PLUS3, 16'h00FD, 8'h17, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'hC000, 8'h00, ram_addr(3'd0, 16'hC000), 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_PLUS3, 16'h7FFD, 8'h10, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'h0000, 8'h00, rom_addr(2'd1, 16'h0000), 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_PLUS3, 16'h1FFD, 8'h04, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'h0001, 8'h00, rom_addr(2'd3, 16'h0001), 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_PLUS3, 16'h7FFD, 8'h00, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'h0002, 8'h00, rom_addr(2'd2, 16'h0002), 1'b0, 1'b0);
		// Special configurations 0 to 3
		add_row(OP_IOWR, MODEL_PLUS3, 16'h1FFD, 8'h01, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'h4010, 8'h00, ram_addr(3'd1, 16'h4010), 1'b0, 1'b0);
		add_row(OP_MWR, MODEL_PLUS3, 16'h0020, 8'h00, ram_addr(3'd0, 16'h0020), 1'b1, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'hC010, 8'h00, ram_addr(3'd3, 16'hC010), 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_PLUS3, 16'h1FFD, 8'h03, '0, 1'b0, 1'b0);
		add_row(OP_MWR, MODEL_PLUS3, 16'h0001, 8'h00, ram_addr(3'd4, 16'h0001), 1'b1, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'h8000, 8'h00, ram_addr(3'd6, 16'h8000), 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'hC000, 8'h00, ram_addr(3'd7, 16'hC000), 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_PLUS3, 16'h1FFD, 8'h05, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'h4000, 8'h00, ram_addr(3'd5, 16'h4000), 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'hC000, 8'h00, ram_addr(3'd3, 16'hC000), 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_PLUS3, 16'h1FFD, 8'h07, '0, 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'h0000, 8'h00, ram_addr(3'd4, 16'h0000), 1'b0, 1'b0);
		add_row(OP_MRD, MODEL_PLUS3, 16'h4000, 8'h00, ram_addr(3'd7, 16'h4000), 1'b0, 1'b0);
		add_row(OP_IOWR, MODEL_PLUS3, 16'h1FFD, 8'h00, '0, 1'b0, 1'b0);
		add_row(OP_MWR, MODEL_PLUS3, 16'h0003, 8'h00, rom_addr(2'd0, 16'h0003), 1'b0, 1'b0);
		// ULA writes must leave bank 3 and the screen bit alone
		add_row(OP_IOWR, MODEL_PLUS3, 16'h7FFD, 8'h0B, '0, 1'b0, 1'b1);
		repeat (4) add_ula(1'b1);
		add_row(OP_MRD, MODEL_PLUS3, 16'hC000, 8'h00, ram_addr(3'd3, 16'hC000), 1'b0, 1'b1);
		add_row(OP_MRD, MODEL_PLUS3, 16'h0000, 8'h00, rom_addr(2'd0, 16'h0000), 1'b0, 1'b1);

		wd_ns    = rows.size() * 8 * 4 + 400;
		wd_armed = 1'b1;
		foreach (rows[i])
			run_row(rows[i]);
		@(posedge clk_sys);
		if (uut.u_chk.fail_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("Assertion checker reported %0d failures", uut.u_chk.fail_count);
			$display("RESULT: FAIL");
			$fatal(1, "assertion failures");
		end
	end

	initial begin
		wait (wd_armed);
		#(wd_ns);
		$display("TIMEOUT: stimulus table did not finish within %0d ns", wd_ns);
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== sources.f ====
+incdir+common
common/zx_pkg.sv
src/port_decode.sv
paging/port_regs.sv
paging/mem_map.sv
src/zx_paging_top.sv
dv/zx_paging_chk.sv
dv/zx_paging_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the paging testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module zx_paging_tb \
	-o zx_paging_sim || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/zx_paging_sim 2>&1)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS' \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
